//--- verilog/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

`define BP_HIST_BITS   10             // history length and table index width.
`define BP_TABLE_DEPTH (1 << `BP_HIST_BITS)

// rv32i control-flow opcodes
`define BP_OP_BR       7'b1100011
`define BP_OP_JAL      7'b1101111
`define BP_OP_JALR     7'b1100111

`define BP_CTR_RESET   2'b01          // weakly not taken.

`endif

//--- verilog/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

    typedef logic [31:0]                  pc_t;
    typedef logic [`BP_HIST_BITS-1:0]     hist_t;   // also the table index.
    typedef logic [1:0]                   ctr_t;
    typedef logic [6:0]                   opcode_t;

    // retired instruction as seen by writeback
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        pc_t     pc;
        pc_t     next_pc;
    } wb_update_t;

    typedef enum logic [0:0] {
        CLEAR = 1'b0,
        RUN   = 1'b1
    } bp_state_e;

endpackage

//--- verilog/bp_history_reg.sv
module bp_history_reg
    import bp_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  shift,
    input  logic  taken,
    output hist_t hist
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist <= '0;
        end else if (shift) begin
            hist <= {hist[$bits(hist_t)-2:0], taken};  // newest outcome in bit 0.
        end
    end

    a_taken_known: assert property (@(posedge clk) disable iff (!rst_n)
        shift |-> !$isunknown(taken));

endmodule

//--- verilog/bp_pht.sv
`include "bp_consts.svh"

module bp_pht
    import bp_pkg::*;
(
    input  logic  clk,
    // fetch-side lookup
    input  hist_t pred_idx,
    output ctr_t  pred_ctr,
    // writeback-side lookup
    input  hist_t upd_idx,
    output ctr_t  upd_ctr,
    // single write port
    input  logic  we,
    input  hist_t wr_idx,
    input  ctr_t  wr_ctr
);

    ctr_t ctr_mem [`BP_TABLE_DEPTH];  // filled by the clear sweep.

    assign pred_ctr = ctr_mem[pred_idx];
    assign upd_ctr  = ctr_mem[upd_idx];

    always_ff @(posedge clk) begin
        if (we) begin
            ctr_mem[wr_idx] <= wr_ctr;
        end
    end

endmodule

//--- verilog/bp_btb.sv
`include "bp_consts.svh"

module bp_btb
    import bp_pkg::*;
(
    input  logic  clk,
    input  hist_t pred_idx,
    output pc_t   pred_tgt,
    input  hist_t upd_idx,
    output pc_t   upd_tgt,
    input  logic  we,
    input  hist_t wr_idx,
    input  pc_t   wr_tgt
);

    // untagged, so aliasing branches share an entry
    pc_t tgt_mem [`BP_TABLE_DEPTH];

    assign pred_tgt = tgt_mem[pred_idx];
    assign upd_tgt  = tgt_mem[upd_idx];   // old target, kept on not-taken.

    always_ff @(posedge clk) begin
        if (we) begin
            tgt_mem[wr_idx] <= wr_tgt;
        end
    end

endmodule

//--- verilog/bp_sweep_counter.sv
`include "bp_consts.svh"

module bp_sweep_counter
    import bp_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    output hist_t idx,
    output logic  last
);

    assign last = (idx == hist_t'(`BP_TABLE_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (run) begin
            idx <= idx + hist_t'(1);
        end
    end

    // the owner must drop run once the top index has been written
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        (run && last) |=> !run);

endmodule

//--- verilog/bp_update_ctl.sv
`include "bp_consts.svh"

module bp_update_ctl
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_buffers,
    input  wb_update_t wb,
    input  hist_t      hist,
    input  ctr_t       upd_ctr,
    input  pc_t        upd_tgt,
    output hist_t      upd_idx,
    output logic       tbl_we,
    output hist_t      tbl_idx,
    output ctr_t       tbl_ctr,
    output pc_t        tbl_tgt,
    output logic       hist_shift,
    output logic       hist_taken,
    output logic       ready
);

    bp_state_e state;
    hist_t     sweep_idx;
    logic      sweep_last;
    logic      is_ctl;
    logic      sample;
    logic      taken;
    logic      wr_valid;
    hist_t     wr_idx;
    ctr_t      wr_ctr;
    pc_t       wr_tgt;
    logic      wr_taken;

    function automatic ctr_t ctr_step(input ctr_t c, input logic t);
        ctr_t n;
        if (t) begin
            n = (c == 2'b11) ? c : c + 2'd1;
        end else begin
            n = (c == 2'b00) ? c : c - 2'd1;
        end
        return n;
    endfunction

    bp_sweep_counter u_sweep (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (state == CLEAR),
        .idx   (sweep_idx),
        .last  (sweep_last)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= CLEAR;
        end else if (state == CLEAR && sweep_last) begin
            state <= RUN;
        end
    end

    assign is_ctl  = (wb.opcode == `BP_OP_BR) || (wb.opcode == `BP_OP_JAL) ||
                     (wb.opcode == `BP_OP_JALR);
    assign sample  = (state == RUN) && load_buffers && wb.valid && is_ctl;
    assign taken   = (wb.next_pc != wb.pc + 32'd4);
    assign upd_idx = wb.pc[`BP_HIST_BITS-1:0] ^ hist;  // same index the write will use.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= sample;
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            wr_idx   <= upd_idx;
            wr_ctr   <= ctr_step(upd_ctr, taken);
            wr_tgt   <= taken ? wb.next_pc : upd_tgt;
            wr_taken <= taken;
        end
    end

    // sweep owns the write port until the tables are initialized
    assign tbl_we     = (state == CLEAR) ? 1'b1 : wr_valid;
    assign tbl_idx    = (state == CLEAR) ? sweep_idx : wr_idx;
    assign tbl_ctr    = (state == CLEAR) ? `BP_CTR_RESET : wr_ctr;
    assign tbl_tgt    = (state == CLEAR) ? '0 : wr_tgt;
    assign hist_shift = wr_valid;
    assign hist_taken = wr_taken;
    assign ready      = (state == RUN);

    a_shift_with_write: assert property (@(posedge clk) disable iff (!rst_n)
        hist_shift |-> (tbl_we && state == RUN));

    // ready comes up only at the end of the sweep and then stays up
    a_ready_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> $past(sweep_last));
    a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> ready);

endmodule

//--- verilog/gshare_predictor.sv
`include "bp_consts.svh"

module gshare_predictor
    import bp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pc_t        if_pc,
    output pc_t        pred_pc,
    input  logic       load_buffers,
    input  wb_update_t wb,
    output logic       ready
);

    hist_t hist;
    hist_t pred_idx;
    ctr_t  pred_ctr;
    pc_t   pred_tgt;
    hist_t upd_idx;
    ctr_t  upd_ctr;
    pc_t   upd_tgt;
    logic  tbl_we;
    hist_t tbl_idx;
    ctr_t  tbl_ctr;
    pc_t   tbl_tgt;
    logic  hist_shift;
    logic  hist_taken;

    assign pred_idx = if_pc[`BP_HIST_BITS-1:0] ^ hist;  // gshare index.
    assign pred_pc  = (ready && pred_ctr[1]) ? pred_tgt : if_pc + 32'd4;

    bp_history_reg u_hist (
        .clk   (clk),
        .rst_n (rst_n),
        .shift (hist_shift),
        .taken (hist_taken),
        .hist  (hist)
    );

    bp_pht u_pht (
        .clk      (clk),
        .pred_idx (pred_idx),
        .pred_ctr (pred_ctr),
        .upd_idx  (upd_idx),
        .upd_ctr  (upd_ctr),
        .we       (tbl_we),
        .wr_idx   (tbl_idx),
        .wr_ctr   (tbl_ctr)
    );

    bp_btb u_btb (
        .clk      (clk),
        .pred_idx (pred_idx),
        .pred_tgt (pred_tgt),
        .upd_idx  (upd_idx),
        .upd_tgt  (upd_tgt),
        .we       (tbl_we),
        .wr_idx   (tbl_idx),
        .wr_tgt   (tbl_tgt)
    );

    bp_update_ctl u_ctl (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_buffers (load_buffers),
        .wb           (wb),
        .hist         (hist),
        .upd_ctr      (upd_ctr),
        .upd_tgt      (upd_tgt),
        .upd_idx      (upd_idx),
        .tbl_we       (tbl_we),
        .tbl_idx      (tbl_idx),
        .tbl_ctr      (tbl_ctr),
        .tbl_tgt      (tbl_tgt),
        .hist_shift   (hist_shift),
        .hist_taken   (hist_taken),
        .ready        (ready)
    );

endmodule

//--- verif/gshare_predictor_tb.sv
`include "bp_consts.svh"

module gshare_predictor_tb
    import bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int      DEPTH       = `BP_TABLE_DEPTH;
    localparam int      CLEAR_LIMIT = 4 * `BP_TABLE_DEPTH;
    localparam opcode_t OP_ALU      = 7'b0110011;          // r-type, not control flow.
    localparam hist_t   TRAIN_IDX   = 10'h155;
    localparam hist_t   SAT_IDX     = 10'h2a7;
    localparam pc_t     TRAIN_TGT   = 32'h0000_8a40;
    localparam pc_t     SAT_TGT     = 32'h0001_0c00;

    logic       clk;
    logic       rst_n;
    pc_t        if_pc;
    pc_t        pred_pc;
    logic       load_buffers;
    wb_update_t wb;
    logic       ready;

    int          errors;
    int          checks;
    logic        timed_out;
    logic [31:0] lcg_state;

    // reference model of the predictor state
    hist_t m_hist;
    ctr_t  m_ctr [DEPTH];
    pc_t   m_tgt [DEPTH];

    gshare_predictor DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .if_pc        (if_pc),
        .pred_pc      (pred_pc),
        .load_buffers (load_buffers),
        .wb           (wb),
        .ready        (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void model_reset();
        m_hist = '0;
        for (int i = 0; i < DEPTH; i++) begin
            m_ctr[i] = `BP_CTR_RESET;
            m_tgt[i] = '0;
        end
    endfunction

    function automatic pc_t model_pred(input pc_t pc);
        hist_t idx;
        idx = pc[`BP_HIST_BITS-1:0] ^ m_hist;
        if (m_ctr[idx] >= 2'b10) begin
            return m_tgt[idx];
        end
        return pc + 32'd4;
    endfunction

    function automatic void model_update(input wb_update_t u, input logic lb);
        hist_t idx;
        logic  tk;
        logic  ctl;
        ctl = (u.opcode == `BP_OP_BR) || (u.opcode == `BP_OP_JAL) ||
              (u.opcode == `BP_OP_JALR);
        if (lb && u.valid && ctl) begin
            idx = u.pc[`BP_HIST_BITS-1:0] ^ m_hist;
            tk  = (u.next_pc != u.pc + 32'd4);
            if (tk) begin
                m_tgt[idx] = u.next_pc;
                if (m_ctr[idx] != 2'b11) begin
                    m_ctr[idx] = m_ctr[idx] + 2'd1;
                end
            end else if (m_ctr[idx] != 2'b00) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
            m_hist = {m_hist[`BP_HIST_BITS-2:0], tk};
        end
    endfunction

    // a pc whose gshare index is idx under the current history
    function automatic pc_t pc_at_index(input pc_t base, input hist_t idx);
        return {base[31:`BP_HIST_BITS], idx ^ m_hist};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic check_pred(input string name, input pc_t pc, input pc_t exp);
        if_pc = pc;
        #1;
        check_value(name, exp, pred_pc);
        @(posedge clk);
        #1;
    endtask

    // sampled at the next edge, visible to fetch one edge later
    task automatic send_update(input opcode_t op, input pc_t pc, input pc_t next_pc,
                               input logic lb, input logic valid);
        wb_update_t u;
        u.valid      = valid;
        u.opcode     = op;
        u.pc         = pc;
        u.next_pc    = next_pc;
        wb           = u;
        load_buffers = lb;
        model_update(u, lb);
        @(posedge clk);
        #1;
        wb           = '0;
        load_buffers = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic test_clear();
        int  cycles;
        pc_t pc;
        cycles = 0;
        check_value("test_clear", 32'd0, {31'd0, ready});
        while (!ready && cycles < CLEAR_LIMIT) begin
            pc    = lcg_next();
            if_pc = pc;
            #1;
            check_value("test_clear", pc + 32'd4, pred_pc);
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ready) begin
            errors++;
            timed_out = 1'b1;
            $display("Error: test_clear timed out, ready stayed low for %0d cycles", cycles);
        end else begin
            check_value("test_clear", 32'(DEPTH), 32'(cycles));
        end
    endtask

    task automatic test_cold();
        pc_t pc;
        for (int i = 0; i < 64; i++) begin
            pc = 32'h0000_4000 + 32'(i * 4);
            check_pred("test_cold", pc, pc + 32'd4);
        end
    endtask

    task automatic test_train_taken();
        pc_t pc;
        repeat (2) begin
            send_update(`BP_OP_BR, pc_at_index(32'h0000_1000, TRAIN_IDX), TRAIN_TGT,
                        1'b1, 1'b1);
        end
        check_pred("test_train_taken", pc_at_index(32'h0000_3000, TRAIN_IDX), TRAIN_TGT);
        for (int i = 1; i <= 16; i++) begin
            pc = pc_at_index(32'h0000_3000, TRAIN_IDX ^ hist_t'(i));
            check_pred("test_train_taken", pc, pc + 32'd4);
        end
    endtask

    task automatic test_saturation();
        pc_t pc;
        repeat (3) begin
            send_update(`BP_OP_BR, pc_at_index(32'h0000_5000, SAT_IDX), SAT_TGT,
                        1'b1, 1'b1);
        end
        check_pred("test_saturation", pc_at_index(32'h0000_5000, SAT_IDX), SAT_TGT);
        pc = pc_at_index(32'h0000_5000, SAT_IDX);
        send_update(`BP_OP_BR, pc, pc + 32'd4, 1'b1, 1'b1);
        check_pred("test_saturation", pc_at_index(32'h0000_5000, SAT_IDX), SAT_TGT);
        pc = pc_at_index(32'h0000_5000, SAT_IDX);
        send_update(`BP_OP_BR, pc, pc + 32'd4, 1'b1, 1'b1);
        pc = pc_at_index(32'h0000_5000, SAT_IDX);
        check_pred("test_saturation", pc, pc + 32'd4);
    endtask

    task automatic test_gating();
        pc_t pc;
        pc = pc_at_index(32'h0000_6000, SAT_IDX);
        send_update(`BP_OP_BR, pc, SAT_TGT, 1'b0, 1'b1);
        send_update(`BP_OP_JAL, pc, SAT_TGT, 1'b1, 1'b0);
        send_update(OP_ALU, pc, SAT_TGT, 1'b1, 1'b1);
        // a shifted history would move both lookups off their entries
        check_pred("test_gating", pc_at_index(32'h0000_6000, TRAIN_IDX), TRAIN_TGT);
        pc = pc_at_index(32'h0000_6000, SAT_IDX);
        check_pred("test_gating", pc, pc + 32'd4);
    endtask

    task automatic test_random();
        logic [31:0] r;
        opcode_t     op;
        pc_t         pc;
        pc_t         next_pc;
        pc_t         probe;
        hist_t       idx;
        for (int i = 0; i < 300; i++) begin
            r  = lcg_next();
            pc = {20'h00012, r[25:16], 2'b00};
            r  = lcg_next();
            case (r[31:30])
                2'd0:    op = `BP_OP_BR;
                2'd1:    op = `BP_OP_JAL;
                2'd2:    op = `BP_OP_JALR;
                default: op = OP_ALU;
            endcase
            next_pc = r[29] ? {16'h0002, r[22:9], 2'b00} : pc + 32'd4;
            idx     = pc[`BP_HIST_BITS-1:0] ^ m_hist;
            send_update(op, pc, next_pc, r[28:26] != 3'd0, r[25:23] != 3'd0);
            check_pred("test_random", pc, model_pred(pc));
            probe = pc_at_index(32'h0003_4000, idx);  // hits the entry just trained.
            check_pred("test_random", probe, model_pred(probe));
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        if_pc        = '0;
        load_buffers = 1'b0;
        wb           = '0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'd61455;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_clear();
        if (!timed_out) begin
            test_cold();
            test_train_taken();
            test_saturation();
            test_gating();
            test_random();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- gshare_predictor.f
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_history_reg.sv
verilog/bp_pht.sv
verilog/bp_btb.sv
verilog/bp_sweep_counter.sv
verilog/bp_update_ctl.sv
verilog/gshare_predictor.sv
verif/gshare_predictor_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module gshare_predictor_tb \
    -f gshare_predictor.f

out=$(./obj_dir/Vgshare_predictor_tb)
echo "$out"

if grep -qx "STATUS: PASS" <<< "$out"; then
    exit 0
fi
exit 1
